// ==== tb.f ====
src/dmaPkg.sv
src/programDecoder.sv
src/channelRegFile.sv
src/priorityArbiter.sv
src/transferSequencer.sv
src/dmaTop.sv
testbench/dmaTb.sv

// ==== Bender.yml ====
package:
  name: dma_controller

sources:
  - files:
      - src/dmaPkg.sv
      - src/programDecoder.sv
      - src/channelRegFile.sv
      - src/priorityArbiter.sv
      - src/transferSequencer.sv
      - src/dmaTop.sv
  - target: test
    files:
      - testbench/dmaTb.sv

// ==== testbench/dmaTb.sv ====
`timescale 1ns/100ps
`default_nettype none

module dmaTb
	import dmaPkg::*;
;

	localparam int roundCount = 8;

	logic busIf = 1'b0;
	logic reset;
	logic csN;
	logic cpuWrite;
	regAddrT regAddr;
	byteT dataIn;
	chanMaskT dreq;
	logic hlda;
	logic hrq;
	logic aen;
	logic adstb;
	addrT address;
	chanMaskT dack;
	logic iorN;
	logic memwN;
	logic tc;

	// reference model of the channel registers and arbitration state
	addrT modelAddr [channelCount];
	addrT modelCount [channelCount];
	int modelLast = channelCount - 1;
	logic modelRotate = 1'b0;

	int seed = 32'h56dc9e1f;
	int cycleCount = 0;
	// reset and first programming round, grows with every round after that
	int cycleLimit = 40;

	dmaTop dmaTop_i (
		.busIf(busIf), .reset(reset), .csN(csN), .cpuWrite(cpuWrite),
		.regAddr(regAddr), .dataIn(dataIn), .dreq(dreq), .hlda(hlda),
		.hrq(hrq), .aen(aen), .adstb(adstb), .address(address),
		.dack(dack), .iorN(iorN), .memwN(memwN), .tc(tc)
	);

	// 20 ns period
	always #10 busIf = !busIf;

	task automatic stopWithFailure();
		$display("*** FAILED ***");
		$fatal(1, "simulation stopped at the first failure");
	endtask

	task automatic checkAddr(addrT actual, addrT expected, string what);
		if (actual !== expected)
		begin
			$display("** Error at %0t: %s is %h, expected %h", $time, what, actual, expected);
			stopWithFailure();
		end
	endtask

	task automatic checkMask(chanMaskT actual, chanMaskT expected, string what);
		if (actual !== expected)
		begin
			$display("** Error at %0t: %s is %b, expected %b", $time, what, actual, expected);
			stopWithFailure();
		end
	endtask

	task automatic checkFlag(logic actual, logic expected, string what);
		if (actual !== expected)
		begin
			$display("** Error at %0t: %s is %b, expected %b", $time, what, actual, expected);
			stopWithFailure();
		end
	endtask

	// run limit tracks the planned transfers
	always @(posedge busIf)
	begin
		cycleCount <= cycleCount + 1;
		if (cycleCount > cycleLimit)
		begin
			$display("Timeout: the run did not finish within %0d cycles", cycleLimit);
			stopWithFailure();
		end
	end

	// channels whose model count is still nonzero
	function automatic chanMaskT activeMask();
		chanMaskT mask;
		for (int i = 0; i < channelCount; i++)
			mask[i] = (modelCount[i] != '0);
		return mask;
	endfunction

	// fixed order from channel zero, rotating order from one above the last served
	function automatic chanT expectedChannel(chanMaskT req);
		chanT pick;
		int start;
		int c;
		logic found;
		pick = '0;
		found = 1'b0;
		start = modelRotate ? (modelLast + 1) % channelCount : 0;
		for (int i = 0; i < channelCount; i++)
		begin
			c = (start + i) % channelCount;
			if (!found && req[c])
			begin
				pick = chanT'(c);
				found = 1'b1;
			end
		end
		return pick;
	endfunction

	// one cpu write cycle, called on a falling edge
	task automatic writeReg(int offset, byteT data);
		csN = 1'b0;
		cpuWrite = 1'b1;
		regAddr = regAddrT'(offset);
		dataIn = data;
		@(negedge busIf);
	endtask

	task automatic programChannels();
		addrT a;
		addrT c;
		int total;
		total = 0;
		// stray byte leaves the pointer on the high byte, so the clear must work
		writeReg(0, byteT'($random(seed)));
		writeReg(clearPointerOffset, byteT'($random(seed)));
		for (int ch = 0; ch < channelCount; ch++)
		begin
			a = addrT'($random(seed));
			c = addrT'(($unsigned($random(seed)) % 6) + 1);
			// low byte first, the pointer flips after each byte
			writeReg(2 * ch, a[7:0]);
			writeReg(2 * ch, a[15:8]);
			writeReg(2 * ch + 1, c[7:0]);
			writeReg(2 * ch + 1, c[15:8]);
			modelAddr[ch] = a;
			modelCount[ch] = c;
			total += c;
		end
		modelRotate = $random(seed) & 1;
		writeReg(cmdRegOffset, byteT'(modelRotate) << rotatePriorityBit);
		csN = 1'b1;
		cpuWrite = 1'b0;
		cycleLimit += total * 40 + 20;
	endtask

	task automatic runTransfer();
		chanMaskT req;
		chanMaskT expDack;
		chanT ch;
		int delay;
		// inactive channels may still request and must be ignored
		req = chanMaskT'($random(seed));
		if ((req & activeMask()) == '0)
			req = req | activeMask();
		dreq = req;
		while (hrq !== 1'b1)
			@(negedge busIf);
		checkFlag(aen, 1'b0, "aen in SO");
		checkFlag(adstb, 1'b0, "adstb in SO");
		delay = $unsigned($random(seed)) % 5;
		repeat (delay)
		begin
			@(negedge busIf);
			checkFlag(hrq, 1'b1, "hrq while waiting for hlda");
			checkFlag(aen, 1'b0, "aen while waiting for hlda");
		end
		hlda = 1'b1;
		// grant is taken at the next rising edge
		ch = expectedChannel(req & activeMask());
		expDack = chanMaskT'(1) << ch;
		modelLast = ch;
		@(negedge busIf);
		checkFlag(adstb, 1'b1, "adstb in S1");
		checkFlag(aen, 1'b1, "aen in S1");
		checkFlag(iorN, 1'b1, "iorN in S1");
		checkFlag(memwN, 1'b1, "memwN in S1");
		checkMask(dack, '0, "dack in S1");
		checkAddr(address, modelAddr[ch], "address at adstb");
		@(negedge busIf);
		checkFlag(adstb, 1'b0, "adstb in S2");
		checkFlag(aen, 1'b1, "aen in S2");
		checkFlag(iorN, 1'b0, "iorN in S2");
		checkFlag(memwN, 1'b0, "memwN in S2");
		checkMask(dack, expDack, "dack in S2");
		checkFlag(tc, 1'b0, "tc in S2");
		checkAddr(address, modelAddr[ch], "address in S2");
		@(negedge busIf);
		checkFlag(aen, 1'b0, "aen in S4");
		checkFlag(iorN, 1'b1, "iorN in S4");
		checkFlag(memwN, 1'b1, "memwN in S4");
		checkFlag(hrq, 1'b1, "hrq in S4");
		checkMask(dack, expDack, "dack in S4");
		checkFlag(tc, modelCount[ch] == addrT'(1), "tc in S4");
		checkAddr(address, modelAddr[ch], "address in S4");
		modelAddr[ch] = modelAddr[ch] + 1'b1;
		modelCount[ch] = modelCount[ch] - 1'b1;
		@(negedge busIf);
		// back in SI, three cycles after adstb
		checkFlag(hrq, 1'b0, "hrq after S4");
		checkMask(dack, '0, "dack after S4");
		checkFlag(tc, 1'b0, "tc after S4");
		hlda = 1'b0;
	endtask

	initial
	begin
		reset = 1'b1;
		csN = 1'b1;
		cpuWrite = 1'b0;
		regAddr = '0;
		dataIn = '0;
		dreq = '0;
		hlda = 1'b0;
		for (int i = 0; i < channelCount; i++)
		begin
			modelAddr[i] = '0;
			modelCount[i] = '0;
		end
		repeat (3) @(posedge busIf);
		@(negedge busIf);
		reset = 1'b0;
		// idle bus after reset
		checkFlag(hrq, 1'b0, "hrq after reset");
		checkFlag(aen, 1'b0, "aen after reset");
		checkFlag(iorN, 1'b1, "iorN after reset");
		checkFlag(memwN, 1'b1, "memwN after reset");
		checkMask(dack, '0, "dack after reset");
		for (int round = 0; round < roundCount; round++)
		begin
			programChannels();
			while (activeMask() != '0)
				runTransfer();
			dreq = '0;
		end
		$display("*** PASSED ***");
		$finish;
	end

endmodule

`default_nettype wire

// ==== src/dmaTop.sv ====
`timescale 1ns/100ps
`default_nettype none

module dmaTop
	import dmaPkg::*;
(
	input logic busIf,
	input logic reset,
	input logic csN,
	input logic cpuWrite,
	input regAddrT regAddr,
	input byteT dataIn,
	input chanMaskT dreq,
	input logic hlda,
	output logic hrq,
	output logic aen,
	output logic adstb,
	output addrT address,
	output chanMaskT dack,
	output logic iorN,
	output logic memwN,
	output logic tc
);

	// decoder to register file
	logic regWrite;
	chanT regChan;
	fieldT regField;
	logic highByte;
	byteT regData;
	// decoder to arbiter
	logic rotatePriority;
	// register file to arbiter and sequencer
	chanMaskT chanActive;
	addrT chanAddr;
	addrT chanCount;
	// arbiter and sequencer handshake
	chanMaskT grant;
	logic grantTake;
	logic transferDone;
	chanT transferChan;

	programDecoder programDecoder_i (
		.busIf(busIf),
		.reset(reset),
		.csN(csN),
		.cpuWrite(cpuWrite),
		.regAddr(regAddr),
		.dataIn(dataIn),
		.regWrite(regWrite),
		.regChan(regChan),
		.regField(regField),
		.highByte(highByte),
		.regData(regData),
		.rotatePriority(rotatePriority)
	);

	channelRegFile channelRegFile_i (
		.busIf(busIf),
		.reset(reset),
		.regWrite(regWrite),
		.regChan(regChan),
		.regField(regField),
		.highByte(highByte),
		.regData(regData),
		.transferDone(transferDone),
		.transferChan(transferChan),
		.chanAddr(chanAddr),
		.chanCount(chanCount),
		.chanActive(chanActive)
	);

	priorityArbiter priorityArbiter_i (
		.busIf(busIf),
		.reset(reset),
		.dreq(dreq),
		.chanActive(chanActive),
		.rotatePriority(rotatePriority),
		.grantTake(grantTake),
		.grant(grant)
	);

	transferSequencer transferSequencer_i (
		.busIf(busIf),
		.reset(reset),
		.dreq(dreq),
		.chanActive(chanActive),
		.hlda(hlda),
		.grant(grant),
		.chanAddr(chanAddr),
		.chanCount(chanCount),
		.grantTake(grantTake),
		.transferDone(transferDone),
		.transferChan(transferChan),
		.hrq(hrq),
		.aen(aen),
		.adstb(adstb),
		.iorN(iorN),
		.memwN(memwN),
		.tc(tc),
		.dack(dack),
		.address(address)
	);

endmodule

`default_nettype wire

// ==== src/transferSequencer.sv ====
`timescale 1ns/100ps
`default_nettype none

module transferSequencer
	import dmaPkg::*;
(
	input logic busIf,
	input logic reset,
	input chanMaskT dreq,
	input chanMaskT chanActive,
	input logic hlda,
	input chanMaskT grant,
	input addrT chanAddr,
	input addrT chanCount,
	output logic grantTake,
	output logic transferDone,
	output chanT transferChan,
	output logic hrq,
	output logic aen,
	output logic adstb,
	output logic iorN,
	output logic memwN,
	output logic tc,
	output chanMaskT dack,
	output addrT address
);

	busStateT state;
	busStateT nextState;
	// channel latched when the bus is granted
	chanT servedChan;
	logic requestPending;

	assign requestPending = |(dreq & chanActive);
	// grant is sampled on the edge where hlda is seen in SO
	assign grantTake = (state == stateSO) && hlda && (|grant);

	always_comb
	begin
		nextState = state;
		case (state)
			stateSI:
			begin
				if (requestPending)
					nextState = stateSO;
			end
			stateSO:
			begin
				// wait here for hlda, give up if the request went away
				if (hlda)
					nextState = (|grant) ? stateS1 : stateSI;
			end
			stateS1:
				nextState = stateS2;
			stateS2:
				nextState = stateS4;
			stateS4:
				nextState = stateSI;
			default:
				nextState = stateSI;
		endcase
	end

	always_ff @(posedge busIf)
	begin
		if (reset)
		begin
			state <= stateSI;
			servedChan <= '0;
		end
		else
		begin
			state <= nextState;
			if (grantTake)
				servedChan <= maskToIndex(grant);
		end
	end

	assign transferChan = servedChan;

	// bus outputs decoded from the state
	assign hrq = (state != stateSI);
	assign aen = (state == stateS1) || (state == stateS2);
	assign adstb = (state == stateS1);
	// io read and memory write strobe together in S2
	assign iorN = (state != stateS2);
	assign memwN = (state != stateS2);
	assign transferDone = (state == stateS4);
	// last transfer when the count is one before the update
	assign tc = transferDone && (chanCount == addrT'(1));
	// channel registers only change after S4, so this holds S1 through S4
	assign address = chanAddr;

	always_comb
	begin
		dack = '0;
		if ((state == stateS2) || (state == stateS4))
			dack = chanMaskT'(1) << servedChan;
	end

	adstbOneCycle: assert property (@(posedge busIf) disable iff (reset)
		$rose(adstb) |=> !adstb);

	aenTwoCycles: assert property (@(posedge busIf) disable iff (reset)
		$rose(aen) |=> aen ##1 !aen);

	// one channel acknowledged, held for S2 and S4, then released
	dackOneHotHeld: assert property (@(posedge busIf) disable iff (reset)
		$rose(|dack) |-> $onehot(dack) ##1 ($stable(dack) ##1 !(|dack)));

endmodule

`default_nettype wire

// ==== src/priorityArbiter.sv ====
`timescale 1ns/100ps
`default_nettype none

module priorityArbiter
	import dmaPkg::*;
(
	input logic busIf,
	input logic reset,
	input chanMaskT dreq,
	input chanMaskT chanActive,
	input logic rotatePriority,
	input logic grantTake,
	output chanMaskT grant
);

	chanMaskT maskedReq;
	// last served channel, start of the rotating search is one above it
	chanT lastServed;
	chanT searchBase;
	chanT candidate;

	// requests of finished channels are ignored
	assign maskedReq = dreq & chanActive;

	always_comb
	begin
		grant = '0;
		// fixed priority always starts at channel zero
		searchBase = rotatePriority ? chanT'(lastServed + 1'b1) : chanT'(0);
		// walk down from the farthest offset so the nearest request wins
		for (int offset = channelCount - 1; offset >= 0; offset--)
		begin
			candidate = chanT'(searchBase + offset);
			if (maskedReq[candidate])
				grant = chanMaskT'(1) << candidate;
		end
	end

	always_ff @(posedge busIf)
	begin
		if (reset)
			// channel three so that channel zero is highest after reset
			lastServed <= chanT'(channelCount - 1);
		else if (grantTake)
			lastServed <= maskToIndex(grant);
	end

	// in rotating mode the channel served last loses to any other request
	lastServedLowest: assert property (@(posedge busIf) disable iff (reset)
		rotatePriority && ((maskedReq & ~(chanMaskT'(1) << lastServed)) != '0)
			|-> !grant[lastServed]);

endmodule

`default_nettype wire

// ==== src/channelRegFile.sv ====
`timescale 1ns/100ps
`default_nettype none

module channelRegFile
	import dmaPkg::*;
(
	input logic busIf,
	input logic reset,
	input logic regWrite,
	input chanT regChan,
	input fieldT regField,
	input logic highByte,
	input byteT regData,
	input logic transferDone,
	input chanT transferChan,
	output addrT chanAddr,
	output addrT chanCount,
	output chanMaskT chanActive
);

	// current address and word count per channel
	addrT currentAddr [channelCount];
	addrT wordCount [channelCount];

	always_ff @(posedge busIf)
	begin
		if (reset)
		begin
			// zero count leaves every channel inactive after reset
			for (int i = 0; i < channelCount; i++)
			begin
				currentAddr[i] <= '0;
				wordCount[i] <= '0;
			end
		end
		else if (regWrite)
		begin
			// each byte write replaces one half of the word
			if (regField == fieldAddr)
			begin
				if (highByte)
					currentAddr[regChan][addrWidth-1:byteWidth] <= regData;
				else
					currentAddr[regChan][byteWidth-1:0] <= regData;
			end
			else
			begin
				if (highByte)
					wordCount[regChan][addrWidth-1:byteWidth] <= regData;
				else
					wordCount[regChan][byteWidth-1:0] <= regData;
			end
		end
		else if (transferDone)
		begin
			// step after every transfer, count wraps at its width
			currentAddr[transferChan] <= currentAddr[transferChan] + 1'b1;
			wordCount[transferChan] <= wordCount[transferChan] - 1'b1;
		end
	end

	// registers of the channel in service
	assign chanAddr = currentAddr[transferChan];
	assign chanCount = wordCount[transferChan];

	// a channel takes part in arbitration while its count is nonzero
	always_comb
	begin
		for (int i = 0; i < channelCount; i++)
			chanActive[i] = (wordCount[i] != '0);
	end

	// the sequencer only serves channels that still had a count
	doneOnActiveChan: assert property (@(posedge busIf) disable iff (reset)
		transferDone |-> chanActive[transferChan]);

	// cpu programming and a transfer update never meet
	noWriteDuringDone: assert property (@(posedge busIf) disable iff (reset)
		!(regWrite && transferDone));

endmodule

`default_nettype wire

// ==== src/programDecoder.sv ====
`timescale 1ns/100ps
`default_nettype none

module programDecoder
	import dmaPkg::*;
(
	input logic busIf,
	input logic reset,
	input logic csN,
	input logic cpuWrite,
	input regAddrT regAddr,
	input byteT dataIn,
	output logic regWrite,
	output chanT regChan,
	output fieldT regField,
	output logic highByte,
	output byteT regData,
	output logic rotatePriority
);

	logic cpuAccess;
	logic chanAccess;
	logic cmdAccess;
	logic clearAccess;
	// low or high byte flip-flop
	logic bytePointer;

	// a write cycle is chip select low together with write high
	assign cpuAccess = !csN && cpuWrite;
	// channel registers sit below offset 8, so the top address bit is clear
	assign chanAccess = cpuAccess && !regAddr[regAddrWidth-1];
	assign cmdAccess = cpuAccess && (regAddr == regAddrT'(cmdRegOffset));
	assign clearAccess = cpuAccess && (regAddr == regAddrT'(clearPointerOffset));

	always_ff @(posedge busIf)
	begin
		if (reset)
		begin
			regWrite <= 1'b0;
			bytePointer <= 1'b0;
			rotatePriority <= 1'b0;
		end
		else
		begin
			// one cycle strobe toward the register file
			regWrite <= chanAccess;
			// clear write wins, otherwise flip after every channel byte
			if (clearAccess)
				bytePointer <= 1'b0;
			else if (chanAccess)
				bytePointer <= !bytePointer;
			if (cmdAccess)
				rotatePriority <= dataIn[rotatePriorityBit];
		end
	end

	// payload captured with the strobe
	always_ff @(posedge busIf)
	begin
		if (chanAccess)
		begin
			// channel is address bits two to one, bit zero picks address or count
			regChan <= regAddr[2:1];
			regField <= fieldT'(regAddr[0]);
			highByte <= bytePointer;
			regData <= dataIn;
		end
	end

	// back to back channel writes land on opposite bytes
	byteAlternates: assert property (@(posedge busIf) disable iff (reset)
		regWrite && $past(regWrite) |-> highByte != $past(highByte));

endmodule

`default_nettype wire

// ==== src/dmaPkg.sv ====
`default_nettype none

package dmaPkg;

	// controller geometry
	localparam int channelCount = 4;
	localparam int addrWidth = 16;
	localparam int byteWidth = 8;
	localparam int regAddrWidth = 4;

	// cpu register map, offsets 0 to 7 address the channel registers
	localparam int cmdRegOffset = 8;
	localparam int clearPointerOffset = 12;
	// command data bit that selects rotating priority
	localparam int rotatePriorityBit = 4;

	typedef logic [addrWidth-1:0] addrT;
	typedef logic [byteWidth-1:0] byteT;
	typedef logic [$clog2(channelCount)-1:0] chanT;
	typedef logic [channelCount-1:0] chanMaskT;
	typedef logic [regAddrWidth-1:0] regAddrT;

	// one-hot bus cycle states
	// no S3 here since the controller inserts no wait states
	typedef enum logic [4:0] {
		stateSI = 5'b00001,
		stateSO = 5'b00010,
		stateS1 = 5'b00100,
		stateS2 = 5'b01000,
		stateS4 = 5'b10000
	} busStateT;

	// which word of a channel a register write targets
	typedef enum logic {
		fieldAddr = 1'b0,
		fieldCount = 1'b1
	} fieldT;

	// index of the set bit in a one-hot channel mask
	function automatic chanT maskToIndex(chanMaskT mask);
		chanT index;
		index = '0;
		for (int i = 0; i < channelCount; i++)
		begin
			if (mask[i])
				index = chanT'(i);
		end
		return index;
	endfunction

endpackage

`default_nettype wire
